// File: dv/cpu_tb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module cpu_tb;
    localparam int          PERIOD    = 40;
    localparam int          N_RAND    = 300;                   // Random cycles per phase.
    localparam int          N_CYCLES  = 2 * (N_RAND + 12) + 8;
    localparam int          MEM_BYTES = `DMEM_WORDS * 4;
    localparam logic [4:0]  BASE      = 5'd31;                 // Load/store base register.
    localparam logic [31:0] EBREAK    = 32'h0010_0073;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        halt;
    logic [31:0] halt_code;

    logic [31:0] lcg_state = 32'd19;

    // Reference model state.
    logic [31:0] m_regs [32];
    logic [7:0]  m_mem [MEM_BYTES];
    logic [31:0] m_pc;
    logic [31:0] m_halt_code;
    logic        m_halt;

    // Expected retire record of the instruction in flight.
    logic        p_valid;
    logic [31:0] p_pc;
    logic [4:0]  p_rd;
    logic [31:0] p_data;

    cpu_top cpu_top_inst (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data), .halt(halt), .halt_code(halt_code)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[31:16], lcg_state[31:16] ^ lcg_state[15:0]}; // Mix the weak low bits.
    endfunction

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    // RV32I integer ops by funct3.
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_exec(input logic valid, input logic [31:0] ins);
        logic [31:0] rs1v, rs2v, imm_i, imm_s, imm_b, ea, val, npc;
        logic [4:0]  rd;
        logic        wr;
        logic        taken;
        int          addr;
        p_valid = valid && !m_halt;
        if (p_valid) begin
            rd    = ins[11:7];
            rs1v  = m_regs[ins[19:15]];
            rs2v  = m_regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            wr    = 1'b1;
            val   = 32'h0;
            npc   = m_pc + 32'd4;
            case (ins[6:0])
                7'b0110111: val = {ins[31:12], 12'h0};        // lui
                7'b0010111: val = m_pc + {ins[31:12], 12'h0}; // auipc
                7'b1101111: begin
                    val = m_pc + 32'd4;
                    npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'b1100111: begin
                    val = m_pc + 32'd4;
                    npc = (rs1v + imm_i) & ~32'h1;
                end
                7'b1100011: begin
                    wr = 1'b0;
                    case (ins[14:12])
                        3'd0:    taken = rs1v == rs2v;
                        3'd1:    taken = rs1v != rs2v;
                        3'd4:    taken = $signed(rs1v) < $signed(rs2v);
                        3'd5:    taken = $signed(rs1v) >= $signed(rs2v);
                        3'd6:    taken = rs1v < rs2v;
                        default: taken = rs1v >= rs2v;
                    endcase
                    if (taken)
                        npc = m_pc + imm_b;
                end
                7'b0000011: begin
                    ea   = rs1v + imm_i;
                    addr = int'(ea % 32'(MEM_BYTES)); // Memory wraps.
                    case (ins[14:12])
                        3'd0:    val = {{24{m_mem[addr][7]}}, m_mem[addr]};
                        3'd1:    val = {{16{m_mem[addr + 1][7]}}, m_mem[addr + 1], m_mem[addr]};
                        3'd4:    val = {24'h0, m_mem[addr]};
                        3'd5:    val = {16'h0, m_mem[addr + 1], m_mem[addr]};
                        default: val = {m_mem[addr + 3], m_mem[addr + 2], m_mem[addr + 1],
                                        m_mem[addr]};
                    endcase
                end
                7'b0100011: begin
                    wr   = 1'b0;
                    ea   = rs1v + imm_s;
                    addr = int'(ea % 32'(MEM_BYTES));
                    for (int i = 0; i < (1 << ins[13:12]); i++)
                        m_mem[addr + i] = rs2v[8*i +: 8];
                end
                7'b0010011: val = ref_alu(ins[14:12], ins[14:12] == 3'd5 && ins[30], rs1v, imm_i);
                7'b0110011: val = ref_alu(ins[14:12], ins[30], rs1v, rs2v);
                default: begin
                    // Only ebreak is sent with the system opcode.
                    wr          = 1'b0;
                    m_halt      = 1'b1;
                    m_halt_code = m_regs[10];
                end
            endcase
            if (wr && rd != 5'd0)
                m_regs[rd] = val;
            p_pc   = m_pc;
            p_rd   = wr ? rd : 5'd0;
            p_data = (wr && rd != 5'd0) ? val : 32'h0;
            m_pc   = npc;
        end
    endtask

    task automatic check_retire();
        check_eq(32'(retire_valid), 32'(p_valid), "retire_valid");
        if (p_valid) begin
            check_eq(retire_pc, p_pc, "retire_pc");
            check_eq(32'(retire_rd), 32'(p_rd), "retire_rd");
            check_eq(retire_data, p_data, "retire_data");
        end
        check_eq(pc, m_pc, "pc");
        check_eq(32'(halt), 32'(m_halt), "halt");
        if (m_halt)
            check_eq(halt_code, m_halt_code, "halt_code");
    endtask

    // Drives one cycle and checks what committed on its edge.
    task automatic run_cycle(input logic valid, input logic [31:0] ins);
        @(posedge clk);
        instr_valid <= valid;
        instr       <= ins;
        @(negedge clk);
        check_retire();
        model_exec(valid, ins);
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst         <= 1'b1;
        instr_valid <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < 32; r++)
            m_regs[r] = 32'h0;
        m_pc        = 32'h0;
        m_halt      = 1'b0;
        m_halt_code = 32'h0;
        p_valid     = 1'b0;
    endtask

    function automatic logic [31:0] gen_instr();
        logic [31:0] r;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        r   = lcg_next();
        rd  = 5'(lcg_next() % 31); // Never the base register.
        rs1 = 5'(lcg_next());
        rs2 = 5'(lcg_next());
        f3  = 3'(lcg_next());
        case (r % 12)
            0: return {r[31:12], rd, 7'b0110111};
            1: return {r[31:12], rd, 7'b0010111};
            2, 3: begin
                if (f3 == 3'd1)
                    imm12 = {7'h0, r[24:20]};
                else if (f3 == 3'd5)
                    imm12 = {1'b0, r[30], 5'h0, r[24:20]}; // srli or srai.
                else
                    imm12 = r[31:20];
                return {imm12, rs1, f3, rd, 7'b0010011};
            end
            4, 5: return {1'b0, (f3 == 3'd0 || f3 == 3'd5) && r[30], 5'h0, rs2, rs1, f3, rd,
                          7'b0110011};
            6: return {r[31:12], rd, 7'b1101111};
            7: return {r[31:20], rs1, 3'b000, rd, 7'b1100111};
            8: begin
                if (f3 == 3'd2 || f3 == 3'd3)
                    f3 = f3 | 3'b100;
                return {r[31:25], rs2, rs1, f3, r[11:7], 7'b1100011};
            end
            default: begin
                // Loads and stores near the base, naturally aligned.
                if (r % 12 != 9)
                    f3 = 3'(f3 % 3);
                else if (f3 == 3'd3 || f3 >= 3'd6)
                    f3 = 3'd2;
                imm12 = {6'h0, r[5:0]};
                if (f3[1:0] == 2'd1)
                    imm12[0] = 1'b0;
                else if (f3[1:0] == 2'd2)
                    imm12[1:0] = 2'b00;
                if (r % 12 == 9)
                    return {imm12, BASE, f3, rd, 7'b0000011};
                return {imm12[11:5], rs2, BASE, f3, imm12[4:0], 7'b0100011};
            end
        endcase
    endfunction

    task automatic run_phase(input int n);
        run_cycle(1'b1, {20'h1, BASE, 7'b0110111});                // 0x1000, wraps to 0.
        run_cycle(1'b1, {12'h100, BASE, 3'b000, BASE, 7'b0010011});
        repeat (n) begin
            if (lcg_next() % 5 == 0)
                run_cycle(1'b0, lcg_next()); // Bubble with junk on instr.
            else
                run_cycle(1'b1, gen_instr());
        end
        run_cycle(1'b1, EBREAK);
        repeat (3) run_cycle(1'b1, gen_instr());
    endtask

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'h0;
        for (int i = 0; i < MEM_BYTES; i++)
            m_mem[i] = 8'h0;
        do_reset();
        run_phase(N_RAND);
        do_reset(); // Lands while halted.
        run_phase(N_RAND);
        run_cycle(1'b0, 32'h0);
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #(N_CYCLES * PERIOD * 2 + 200 * PERIOD);
        $display("Timeout: the run did not reach its end in time.");
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired.");
    end

endmodule

// File: run.sh
#!/bin/sh
# Builds the cpu_tb simulation with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/1ps \
    --top-module cpu_tb -Mdir obj_dir -f verilog.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/Vcpu_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi

echo "Simulation finished cleanly"
exit 0

// File: source/alu.sv
`timescale 1ns/1ps
`include "core_config.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  core_pkg::alu_op_e op,
    output logic [`XLEN-1:0] res
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0]; // RV32 shifts use five bits.
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            core_pkg::ALU_ADD:    res = a + b;
            core_pkg::ALU_SUB:    res = a - b;
            core_pkg::ALU_SLL:    res = a << shamt;
            core_pkg::ALU_SLT:    res = {{(`XLEN-1){1'b0}}, lt_signed};
            core_pkg::ALU_SLTU:   res = {{(`XLEN-1){1'b0}}, lt_unsigned};
            core_pkg::ALU_XOR:    res = a ^ b;
            core_pkg::ALU_SRL:    res = a >> shamt;
            core_pkg::ALU_SRA:    res = $unsigned($signed(a) >>> shamt);
            core_pkg::ALU_OR:     res = a | b;
            core_pkg::ALU_AND:    res = a & b;
            core_pkg::ALU_PASS_B: res = b; // lui.
            default:              res = a + b;
        endcase
    end

endmodule

// File: source/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data path width.
`define XLEN 32

// Architectural registers, x0 included.
`define REG_COUNT 32

// Data memory depth in 32-bit words.
// Addresses wrap modulo this size.
`define DMEM_WORDS 256

`endif

// File: source/core_pkg.sv
package core_pkg;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // Operand pairs into the ALU, written as {a, b}.
    typedef enum logic [1:0] {
        OPA_ZERO_IMM = 2'b00,
        OPA_PC_IMM   = 2'b01,
        OPA_RS1_RS2  = 2'b10,
        OPA_RS1_IMM  = 2'b11
    } opa_sel_e;

    // Nine kinds, so four bits.
    typedef enum logic [3:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        opa_sel_e  a_sel;
        br_cond_e  br_cond;
        mem_size_e mem_size;
        logic      mem_write;
        logic      load_signed;
        logic      link;        // Result is pc + 4.
        logic      rd_write;
        logic      is_ebreak;
    } exu_ctrl_t;

endpackage

// File: source/cpu_top.sv
`timescale 1ns/1ps
`include "core_config.svh"

module cpu_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [31:0]                   instr,
    output logic [`XLEN-1:0]              pc,
    output logic                          retire_valid,
    output logic [`XLEN-1:0]              retire_pc,
    output logic [$clog2(`REG_COUNT)-1:0] retire_rd,
    output logic [`XLEN-1:0]              retire_data,
    output logic                          halt,
    output logic [`XLEN-1:0]              halt_code
);
    localparam int RW = $clog2(`REG_COUNT);

    logic [RW-1:0]       rs1, rs2, rd;
    logic [`XLEN-1:0]    imm, rs1_data, rs2_data, rd_data, next_pc;
    core_pkg::exu_ctrl_t ctrl;
    core_pkg::exu_ctrl_t exu_ctrl;
    logic                commit;
    logic                rf_we;

    mem_bus_if dmem_bus ();

    idu idu_inst (.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .ctrl(ctrl));

    // Nothing commits while halted.
    assign commit = instr_valid & ~halt;
    assign rf_we  = commit & ctrl.rd_write;

    always_comb begin
        exu_ctrl           = ctrl;
        exu_ctrl.mem_write = ctrl.mem_write & commit; // Gates wen.
    end

    regfile regfile_inst (
        .clk(clk), .rst(rst), .we(rf_we), .waddr(rd), .wdata(rd_data),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    exu exu_inst (
        .ctrl(exu_ctrl), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .pc(pc), .rd_data(rd_data), .next_pc(next_pc), .dmem(dmem_bus)
    );

    data_mem data_mem_inst (.clk(clk), .mem(dmem_bus));

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= '0;
            halt         <= 1'b0;
            halt_code    <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= commit;
            if (commit) begin
                pc <= next_pc;
                if (ctrl.is_ebreak) begin
                    halt      <= 1'b1;
                    halt_code <= rs1_data; // x10.
                end
            end
        end
    end

    // Retire record of the last committed instruction.
    always_ff @(posedge clk) begin
        if (commit) begin
            retire_pc   <= pc;
            retire_rd   <= rf_we ? rd : '0;
            retire_data <= (rf_we && rd != '0) ? rd_data : '0;
        end
    end

endmodule

// File: source/data_mem.sv
`timescale 1ns/1ps
`include "core_config.svh"

module data_mem (
    input logic       clk,
    mem_bus_if.memory mem
);
    // Zero at start, no reset clear.
    logic [`XLEN-1:0] words [`DMEM_WORDS] = '{default: '0};

    // Byte-masked write at the edge.
    always_ff @(posedge clk) begin
        if (mem.wen) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (mem.wmask[lane])
                    words[mem.addr][8*lane +: 8] <= mem.wdata[8*lane +: 8];
            end
        end
    end

    assign mem.rdata = words[mem.addr]; // Same-cycle read.

endmodule

// File: source/exu.sv
`timescale 1ns/1ps
`include "core_config.svh"

module exu (
    input  core_pkg::exu_ctrl_t ctrl,
    input  logic [`XLEN-1:0]    rs1_data,
    input  logic [`XLEN-1:0]    rs2_data,
    input  logic [`XLEN-1:0]    imm,
    input  logic [`XLEN-1:0]    pc,
    output logic [`XLEN-1:0]    rd_data,
    output logic [`XLEN-1:0]    next_pc,
    mem_bus_if.requester        dmem
);
    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] op_a, op_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] load_word;
    logic [`XLEN-1:0] load_val;
    logic [1:0]       offset;
    logic [4:0]       lane_shift;
    logic             taken;

    always_comb begin
        case (ctrl.a_sel)
            core_pkg::OPA_ZERO_IMM: begin op_a = '0;       op_b = imm;      end
            core_pkg::OPA_PC_IMM:   begin op_a = pc;       op_b = imm;      end
            core_pkg::OPA_RS1_RS2:  begin op_a = rs1_data; op_b = rs2_data; end
            default:                begin op_a = rs1_data; op_b = imm;      end
        endcase
    end

    alu alu_inst (
        .a   (op_a),
        .b   (op_b),
        .op  (ctrl.alu_op),
        .res (alu_res)
    );

    // Branch compare is done here so the ALU stays free for the sum.
    always_comb begin
        case (ctrl.br_cond)
            core_pkg::BR_JAL: taken = 1'b1;
            core_pkg::BR_EQ:  taken = rs1_data == rs2_data;
            core_pkg::BR_NE:  taken = rs1_data != rs2_data;
            core_pkg::BR_LT:  taken = $signed(rs1_data) < $signed(rs2_data);
            core_pkg::BR_GE:  taken = $signed(rs1_data) >= $signed(rs2_data);
            core_pkg::BR_LTU: taken = rs1_data < rs2_data;
            core_pkg::BR_GEU: taken = rs1_data >= rs2_data;
            default:          taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + `XLEN'd4;
    assign next_pc  = (ctrl.br_cond == core_pkg::BR_JALR) ? {alu_res[`XLEN-1:1], 1'b0} :
                      taken ? pc + imm : pc_plus4;

    // Byte lane of the access.
    assign offset = alu_res[1:0];

    always_comb begin
        case (ctrl.mem_size)
            core_pkg::MEM_BYTE: begin lane_shift = {offset, 3'b000};    dmem.wmask = 4'b0001 << offset; end
            core_pkg::MEM_HALF: begin lane_shift = {offset[1], 4'b0000}; dmem.wmask = offset[1] ? 4'b1100 : 4'b0011; end
            core_pkg::MEM_WORD: begin lane_shift = 5'd0;                dmem.wmask = 4'b1111; end
            default:            begin lane_shift = 5'd0;                dmem.wmask = 4'b0000; end
        endcase
    end

    assign dmem.addr  = alu_res[AW+1:2]; // Wraps modulo memory size.
    assign dmem.wdata = rs2_data << lane_shift;
    assign dmem.wen   = ctrl.mem_write;

    assign load_word = dmem.rdata >> lane_shift;

    always_comb begin
        case (ctrl.mem_size)
            core_pkg::MEM_BYTE: load_val = {{(`XLEN-8){load_word[7] & ctrl.load_signed}}, load_word[7:0]};
            core_pkg::MEM_HALF: load_val = {{(`XLEN-16){load_word[15] & ctrl.load_signed}}, load_word[15:0]};
            default:            load_val = load_word;
        endcase
    end

    always_comb begin
        if (ctrl.link)
            rd_data = pc_plus4;
        else if (ctrl.mem_size != core_pkg::MEM_NONE && !ctrl.mem_write)
            rd_data = load_val; // Loads.
        else
            rd_data = alu_res;
    end

endmodule

// File: source/idu.sv
`timescale 1ns/1ps
`include "core_config.svh"

module idu (
    input  logic [31:0]                   instr,
    output logic [$clog2(`REG_COUNT)-1:0] rs1,
    output logic [$clog2(`REG_COUNT)-1:0] rs2,
    output logic [$clog2(`REG_COUNT)-1:0] rd,
    output logic [`XLEN-1:0]              imm,
    output core_pkg::exu_ctrl_t           ctrl
);
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic             is_ebreak;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign is_ebreak = (instr == 32'h0010_0073);

    // ebreak reports x10, so point read port 1 at it.
    assign rs1 = is_ebreak ? 5'd10 : instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // funct3 to ALU op, alt selects sub / sra.
    function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  alu_sel = core_pkg::ALU_SLL;
            3'b010:  alu_sel = core_pkg::ALU_SLT;
            3'b011:  alu_sel = core_pkg::ALU_SLTU;
            3'b100:  alu_sel = core_pkg::ALU_XOR;
            3'b101:  alu_sel = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  alu_sel = core_pkg::ALU_OR;
            default: alu_sel = core_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        // No-op by default.
        ctrl.alu_op      = core_pkg::ALU_ADD;
        ctrl.a_sel       = core_pkg::OPA_ZERO_IMM;
        ctrl.br_cond     = core_pkg::BR_NONE;
        ctrl.mem_size    = core_pkg::MEM_NONE;
        ctrl.mem_write   = 1'b0;
        ctrl.load_signed = 1'b0;
        ctrl.link        = 1'b0;
        ctrl.rd_write    = 1'b0;
        ctrl.is_ebreak   = 1'b0;
        imm              = imm_i;

        case (instr[6:0])
            core_pkg::OPC_LUI: begin
                ctrl.alu_op   = core_pkg::ALU_PASS_B;
                ctrl.rd_write = 1'b1;
                imm           = imm_u;
            end
            core_pkg::OPC_AUIPC: begin
                ctrl.a_sel    = core_pkg::OPA_PC_IMM;
                ctrl.rd_write = 1'b1;
                imm           = imm_u;
            end
            core_pkg::OPC_JAL: begin
                ctrl.br_cond  = core_pkg::BR_JAL;
                ctrl.link     = 1'b1;
                ctrl.rd_write = 1'b1;
                imm           = imm_j;
            end
            core_pkg::OPC_JALR: if (funct3 == 3'b000) begin
                ctrl.a_sel    = core_pkg::OPA_RS1_IMM; // Target from the ALU sum.
                ctrl.br_cond  = core_pkg::BR_JALR;
                ctrl.link     = 1'b1;
                ctrl.rd_write = 1'b1;
            end
            core_pkg::OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  ctrl.br_cond = core_pkg::BR_EQ;
                    3'b001:  ctrl.br_cond = core_pkg::BR_NE;
                    3'b100:  ctrl.br_cond = core_pkg::BR_LT;
                    3'b101:  ctrl.br_cond = core_pkg::BR_GE;
                    3'b110:  ctrl.br_cond = core_pkg::BR_LTU;
                    3'b111:  ctrl.br_cond = core_pkg::BR_GEU;
                    default: ctrl.br_cond = core_pkg::BR_NONE;
                endcase
            end
            core_pkg::OPC_LOAD: if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                ctrl.a_sel       = core_pkg::OPA_RS1_IMM;
                ctrl.mem_size    = core_pkg::mem_size_e'(funct3[1:0] + 2'd1);
                ctrl.load_signed = ~funct3[2];
                ctrl.rd_write    = 1'b1;
            end
            core_pkg::OPC_STORE: if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                ctrl.a_sel     = core_pkg::OPA_RS1_IMM;
                ctrl.mem_size  = core_pkg::mem_size_e'(funct3[1:0] + 2'd1);
                ctrl.mem_write = 1'b1;
                imm            = imm_s;
            end
            core_pkg::OPC_OP_IMM: begin
                ctrl.a_sel    = core_pkg::OPA_RS1_IMM;
                ctrl.alu_op   = alu_sel(funct3, funct3 == 3'b101 && instr[30]);
                ctrl.rd_write = 1'b1;
            end
            core_pkg::OPC_OP: if (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101})) begin
                ctrl.a_sel    = core_pkg::OPA_RS1_RS2;
                ctrl.alu_op   = alu_sel(funct3, instr[30]);
                ctrl.rd_write = 1'b1;
            end
            core_pkg::OPC_SYSTEM: ctrl.is_ebreak = is_ebreak;
            default: ;
        endcase
    end

endmodule

// File: source/mem_bus_if.sv
`timescale 1ns/1ps
`include "core_config.svh"

// Data memory bus, no handshake. Read data is valid in the address cycle.
interface mem_bus_if;
    localparam int AW = $clog2(`DMEM_WORDS);

    logic [AW-1:0]    addr;  // Word index.
    logic [`XLEN-1:0] wdata;
    logic [3:0]       wmask; // One bit per byte lane.
    logic             wen;
    logic [`XLEN-1:0] rdata;

    modport requester (output addr, output wdata, output wmask, output wen, input rdata);

    modport memory (input addr, input wdata, input wmask, input wen, output rdata);

endinterface

// File: source/regfile.sv
`timescale 1ns/1ps
`include "core_config.svh"

module regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  logic [$clog2(`REG_COUNT)-1:0] waddr,
    input  logic [`XLEN-1:0]              wdata,
    input  logic [$clog2(`REG_COUNT)-1:0] raddr1,
    input  logic [$clog2(`REG_COUNT)-1:0] raddr2,
    output logic [`XLEN-1:0]              rdata1,
    output logic [`XLEN-1:0]              rdata2
);
    // x0 has no storage.
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: verilog.f
+incdir+source
source/core_pkg.sv
source/mem_bus_if.sv
source/idu.sv
source/alu.sv
source/exu.sv
source/data_mem.sv
source/regfile.sv
source/cpu_top.sv
dv/cpu_tb.sv
